/* sources.f */
+incdir+verification
source/heapPkg.sv
source/heapAllocIf.sv
source/heapStoreIf.sv
source/arrayAllocator.sv
source/elementStore.sv
source/heapControl.sv
source/heapMemory.sv
verification/heapMemoryTb.sv

/* Bender.yml */
package:
  name: heap_memory

sources:
  - files:
      - source/heapPkg.sv
      - source/heapAllocIf.sv
      - source/heapStoreIf.sv
      - source/arrayAllocator.sv
      - source/elementStore.sv
      - source/heapControl.sv
      - source/heapMemory.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/heapMemoryTb.sv

/* verification/heapTbTasks.svh */
/*
  Heap testbench helpers
  Command task with a done timeout, LFSR data source, test bookkeeping
*/
`ifndef HEAP_TB_TASKS_SVH
`define HEAP_TB_TASKS_SVH

  // ------------------------------
  // Report counters
  // ------------------------------
  int    errorCount    = 0;
  int    errorsAtStart = 0;
  int    checkCount    = 0;
  int    testCount     = 0;
  int    failedTests   = 0;
  bit    timedOut      = 1'b0;   // Stops further commands
  string testName      = "reset";

  logic [15:0] lfsrState = 16'd22965;

  // Taps 16, 14, 13, 11, one step per bit
  function automatic logic [15:0] randomBits(input int count);
    logic [15:0] bits;
    logic        feedback;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], feedback};
      bits      = {bits[14:0], feedback};
    end
    return bits;
  endfunction

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  task automatic finishTest();
    @(negedge clock);  // Let the last done be checked
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("test %s passed", testName);
    end else begin
      failedTests++;
      $display("test %s failed with %0d errors", testName, errorCount - errorsAtStart);
    end
  endtask

  // One request pulse, then wait for done
  task automatic issueCommand(input heapPkg::heapAction_t act, input int arr, input int idx,
                              input int data, input int expectOut,
                              input heapPkg::heapError_t expectError);
    int waitCycles;
    if (timedOut) begin
      return;
    end
    @(negedge clock);
    request       = 1'b1;
    action        = act;
    array         = arrayNumber_t'(arr);
    index         = elementIndex_t'(idx);
    in            = dataWord_t'(data);
    expectedOut   = dataWord_t'(expectOut);
    expectedError = expectError;
    @(negedge clock);
    request    = 1'b0;
    waitCycles = 0;
    while (!done && waitCycles < doneTimeout) begin
      @(negedge clock);
      waitCycles++;
    end
    if (!done) begin
      $display("timeout: no done within %0d cycles after %s in test %s",
               doneTimeout, act.name(), testName);
      errorCount++;
      timedOut = 1'b1;
    end else begin
      checkCount++;
    end
  endtask

`endif

/* verification/heapMemoryTb.sv */
`timescale 1ns/1ns
/*
  Array heap testbench
  Drives commands into the heap and checks every response against its own bookkeeping
*/
module heapMemoryTb;

  localparam int addressBits = heapPkg::defaultAddressBits;
  localparam int indexBits   = heapPkg::defaultIndexBits;
  localparam int dataBits    = heapPkg::defaultDataBits;
  localparam int numArrays   = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;
  localparam int doneTimeout = 20;  // Cycles

  typedef logic [addressBits-1:0] arrayNumber_t;
  typedef logic [indexBits-1:0]   elementIndex_t;
  typedef logic [dataBits-1:0]    dataWord_t;

  logic                 clock;
  logic                 reset;
  logic                 request;
  heapPkg::heapAction_t action;
  arrayNumber_t         array;
  elementIndex_t        index;
  dataWord_t            in;
  dataWord_t            out;
  heapPkg::heapError_t  error;
  logic                 done;

  dataWord_t           expectedOut   = '0;
  heapPkg::heapError_t expectedError = heapPkg::errorNone;
  dataWord_t           pushedValues [$];  // Reference stack for array 0

  `include "heapTbTasks.svh"

  heapMemory #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) dut (
    .clock  (clock),
    .reset  (reset),
    .request(request),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .error  (error),
    .done   (done)
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  // ------------------------------
  // Response checks
  // ------------------------------
  assert property (@(posedge clock) disable iff (!reset) done |-> (out == expectedOut))
    else begin
      errorCount++;
      $display("mismatch in %s: out expected %0d, actual %0d", testName, expectedOut, out);
    end

  assert property (@(posedge clock) disable iff (!reset) done |-> (error == expectedError))
    else begin
      errorCount++;
      $display("mismatch in %s: error expected %s, actual %s",
               testName, expectedError.name(), error.name());
    end

  initial begin : runTests
    dataWord_t value;
    dataWord_t written;
    dataWord_t addend;
    request = 1'b0;
    action  = heapPkg::actionReset;
    array   = '0;
    index   = '0;
    in      = '0;
    reset   = 1'b0;
    repeat (16) @(negedge clock);
    reset = 1'b1;

    startTest("alloc all");
    for (int a = 0; a < numArrays; a++) begin
      issueCommand(heapPkg::actionAlloc, 0, 0, 0, a, heapPkg::errorNone);
    end
    issueCommand(heapPkg::actionAlloc, 0, 0, 0, expectedOut, heapPkg::errorOutOfMemory);
    finishTest();

    startTest("push pop");
    for (int i = 0; i < arrayLength; i++) begin
      value = dataWord_t'(randomBits(dataBits));
      pushedValues.push_back(value);
      issueCommand(heapPkg::actionPush, 0, 0, value, expectedOut, heapPkg::errorNone);
    end
    value = dataWord_t'(randomBits(dataBits));
    issueCommand(heapPkg::actionPush, 0, 0, value, expectedOut, heapPkg::errorOverflow);
    while (pushedValues.size() != 0) begin
      value = pushedValues.pop_back();  // Last in comes out first
      issueCommand(heapPkg::actionPop, 0, 0, 0, value, heapPkg::errorNone);
    end
    issueCommand(heapPkg::actionPop, 0, 0, 0, expectedOut, heapPkg::errorUnderflow);
    finishTest();

    startTest("write size read");
    written = dataWord_t'(randomBits(dataBits));
    issueCommand(heapPkg::actionWrite, 2, 2, written, written, heapPkg::errorNone);
    issueCommand(heapPkg::actionSize, 2, 0, 0, 3, heapPkg::errorNone);
    issueCommand(heapPkg::actionRead, 2, 3, 0, expectedOut, heapPkg::errorOutOfBounds);
    finishTest();

    startTest("add");
    addend = dataWord_t'(randomBits(dataBits));
    value  = dataWord_t'((int'(written) + int'(addend)) % (2 ** dataBits));
    issueCommand(heapPkg::actionAdd, 2, 2, addend, value, heapPkg::errorNone);
    issueCommand(heapPkg::actionRead, 2, 2, 0, value, heapPkg::errorNone);
    finishTest();

    startTest("free");
    issueCommand(heapPkg::actionFree, 1, 0, 0, expectedOut, heapPkg::errorNone);
    issueCommand(heapPkg::actionRead, 1, 0, 0, expectedOut, heapPkg::errorNotAllocated);
    issueCommand(heapPkg::actionFree, 1, 0, 0, expectedOut, heapPkg::errorNotAllocated);
    issueCommand(heapPkg::actionAlloc, 0, 0, 0, 1, heapPkg::errorNone);  // Reused first
    finishTest();

    startTest("reset action");
    value = dataWord_t'(randomBits(dataBits));  // Array 0 holds one element
    issueCommand(heapPkg::actionPush, 0, 0, value, expectedOut, heapPkg::errorNone);
    issueCommand(heapPkg::actionReset, 0, 0, 0, expectedOut, heapPkg::errorNone);
    issueCommand(heapPkg::actionAlloc, 0, 0, 0, 0, heapPkg::errorNone);
    issueCommand(heapPkg::actionSize, 0, 0, 0, 0, heapPkg::errorNone);
    finishTest();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* source/heapMemory.sv */
`timescale 1ns/1ns
/*
  Array heap top level
  Command controller, array allocator and element store on plain ports
*/
module heapMemory #(
  parameter int addressBits = heapPkg::defaultAddressBits,
  parameter int indexBits   = heapPkg::defaultIndexBits,
  parameter int dataBits    = heapPkg::defaultDataBits
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   request,  // One-cycle command strobe
  input  heapPkg::heapAction_t   action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output heapPkg::heapError_t    error,
  output logic                   done      // Result valid, one cycle
);

  heapAllocIf #(.addressBits(addressBits)) allocBus ();

  heapStoreIf #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) storeBus ();

  heapControl #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) control (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .action   (action),
    .array    (array),
    .index    (index),
    .in       (in),
    .out      (out),
    .error    (error),
    .done     (done),
    .allocPort(allocBus),
    .storePort(storeBus)
  );

  arrayAllocator #(.addressBits(addressBits)) allocator (
    .clock    (clock),
    .reset    (reset),
    .allocPort(allocBus)
  );

  elementStore #(
    .addressBits(addressBits),
    .indexBits  (indexBits),
    .dataBits   (dataBits)
  ) store (
    .clock    (clock),
    .reset    (reset),
    .storePort(storeBus)
  );

endmodule

/* source/heapControl.sv */
`timescale 1ns/1ns
/*
  Heap command controller
  Checks each command, strobes allocator and store, registers the result
*/
module heapControl #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 request,
  input  heapPkg::heapAction_t action,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    in,
  output logic [dataBits-1:0]    out,
  output heapPkg::heapError_t  error,
  output logic                 done,
  heapAllocIf.control          allocPort,
  heapStoreIf.control          storePort
);

  localparam int arrayLength = 2 ** indexBits;

  typedef logic [indexBits:0]  arraySize_t;
  typedef logic [dataBits-1:0] dataWord_t;

  heapPkg::heapError_t checkError;  // Outcome of the checks
  dataWord_t           resultWord;
  logic                updateOut;   // Action returns a word
  logic                accepted;    // Request passed all checks
  logic                inBounds;
  logic                hasRoom;
  logic                hasEntries;
  logic                isAlloc;

  assign inBounds   = arraySize_t'(index) < storePort.size;
  assign hasRoom    = storePort.size < arraySize_t'(arrayLength);
  assign hasEntries = storePort.size != '0;
  assign isAlloc    = action == heapPkg::actionAlloc;
  assign accepted   = request && (checkError == heapPkg::errorNone);

  // ------------------------------
  // Checks and result selection
  // ------------------------------
  always_comb begin
    checkError = heapPkg::errorNone;
    resultWord = in;
    updateOut  = 1'b0;
    case (action)
      heapPkg::actionWrite, heapPkg::actionRead, heapPkg::actionSize,
      heapPkg::actionPush, heapPkg::actionPop, heapPkg::actionAdd,
      heapPkg::actionFree: begin
        if (!allocPort.allocated) begin
          checkError = heapPkg::errorNotAllocated;
        end else if ((action == heapPkg::actionRead || action == heapPkg::actionAdd)
                     && !inBounds) begin
          checkError = heapPkg::errorOutOfBounds;
        end else if (action == heapPkg::actionPush && !hasRoom) begin
          checkError = heapPkg::errorOverflow;
        end else if (action == heapPkg::actionPop && !hasEntries) begin
          checkError = heapPkg::errorUnderflow;
        end
        updateOut = (action != heapPkg::actionPush) && (action != heapPkg::actionFree);
        case (action)
          heapPkg::actionRead: resultWord = storePort.element;
          heapPkg::actionSize: resultWord = dataWord_t'(storePort.size);
          heapPkg::actionPop:  resultWord = storePort.top;
          heapPkg::actionAdd:  resultWord = storePort.sum;  // New value
          default:             resultWord = in;             // Write echoes in
        endcase
      end
      heapPkg::actionAlloc: begin
        if (allocPort.exhausted) begin
          checkError = heapPkg::errorOutOfMemory;
        end
        resultWord = dataWord_t'(allocPort.granted);
        updateOut  = 1'b1;
      end
      default: updateOut = 1'b0;  // Reset and unknown codes return nothing
    endcase
  end

  // ------------------------------
  // Strobes, one per accepted command
  // ------------------------------
  assign allocPort.allocate     = accepted && isAlloc;
  assign allocPort.releaseArray = accepted && (action == heapPkg::actionFree);
  assign allocPort.clearAll     = accepted && (action == heapPkg::actionReset);
  assign allocPort.array        = array;

  assign storePort.array        = isAlloc ? allocPort.granted : array;  // Empty the grant
  assign storePort.index        = index;
  assign storePort.data         = in;
  assign storePort.writeElement = accepted && (action == heapPkg::actionWrite);
  assign storePort.pushElement  = accepted && (action == heapPkg::actionPush);
  assign storePort.popElement   = accepted && (action == heapPkg::actionPop);
  assign storePort.addElement   = accepted && (action == heapPkg::actionAdd);
  assign storePort.clearSize    = accepted && isAlloc;

  // ------------------------------
  // Response registers
  // ------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      out   <= '0;
      error <= heapPkg::errorNone;
      done  <= 1'b0;
    end else begin
      done <= request;  // One cycle after each request
      if (request) begin
        error <= checkError;
        if (accepted && updateOut) begin
          out <= resultWord;  // Failed commands keep out
        end
      end
    end
  end

endmodule

/* source/elementStore.sv */
`timescale 1ns/1ns
/*
  Element store
  Element memory and per-array sizes with write, push, pop and add updates
*/
module elementStore #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
) (
  input logic       clock,
  input logic       reset,
  heapStoreIf.store storePort
);

  localparam int numArrays   = 2 ** addressBits;
  localparam int arrayLength = 2 ** indexBits;

  typedef logic [indexBits-1:0] elementIndex_t;
  typedef logic [indexBits:0]   arraySize_t;
  typedef logic [dataBits-1:0]  dataWord_t;

  dataWord_t     memory [numArrays][arrayLength];  // Arrays in fixed blocks
  arraySize_t    sizes  [numArrays];               // Current size per array
  arraySize_t    currentSize;
  elementIndex_t pushIndex;                        // First free slot
  elementIndex_t topIndex;                         // Last used slot
  dataWord_t     element;
  dataWord_t     sum;
  logic          extendsSize;                      // Write lands past the end

  assign currentSize = sizes[storePort.array];
  assign pushIndex   = elementIndex_t'(currentSize);
  assign topIndex    = pushIndex - 1'b1;
  assign element     = memory[storePort.array][storePort.index];
  assign sum         = element + storePort.data;  // Wraps at dataBits
  assign extendsSize = arraySize_t'(storePort.index) >= currentSize;

  // ------------------------------
  // Views towards the controller
  // ------------------------------
  assign storePort.size    = currentSize;
  assign storePort.element = element;
  assign storePort.top     = memory[storePort.array][topIndex];
  assign storePort.sum     = sum;

  // ------------------------------
  // Size updates
  // ------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < numArrays; i++) begin
        sizes[i] <= '0;
      end
    end else if (storePort.clearSize) begin
      sizes[storePort.array] <= '0;
    end else if (storePort.writeElement && extendsSize) begin
      sizes[storePort.array] <= arraySize_t'(storePort.index) + 1'b1;
    end else if (storePort.pushElement) begin
      sizes[storePort.array] <= currentSize + 1'b1;
    end else if (storePort.popElement) begin
      sizes[storePort.array] <= currentSize - 1'b1;
    end
  end

  // ------------------------------
  // Element updates
  // ------------------------------
  always_ff @(posedge clock) begin
    if (storePort.writeElement) begin
      memory[storePort.array][storePort.index] <= storePort.data;
    end else if (storePort.pushElement) begin
      memory[storePort.array][pushIndex] <= storePort.data;
    end else if (storePort.addElement) begin
      memory[storePort.array][storePort.index] <= sum;  // Add in place
    end
  end

  // Controller checks keep every size within the array
  for (genvar a = 0; a < numArrays; a++) begin : sizeCheck
    assert property (@(posedge clock) disable iff (!reset)
      sizes[a] <= arraySize_t'(arrayLength))
      else $error("array %0d has size %0d beyond length %0d", a, sizes[a], arrayLength);
  end

endmodule

/* source/arrayAllocator.sv */
`timescale 1ns/1ns
/*
  Array allocator
  Hands out fresh arrays in order, reuses freed ones last in first out
*/
module arrayAllocator #(
  parameter int addressBits = 2
) (
  input logic           clock,
  input logic           reset,
  heapAllocIf.allocator allocPort
);

  localparam int numArrays = 2 ** addressBits;

  typedef logic [addressBits-1:0] arrayNumber_t;
  typedef logic [addressBits:0]   arrayCount_t;

  arrayCount_t          freshCount;              // Arrays handed out fresh
  arrayCount_t          freedTop;                // Entries on the freed stack
  arrayNumber_t         freedStack [numArrays];  // Freed array numbers
  logic [numArrays-1:0] allocatedFlags;          // One flag per array
  arrayNumber_t         stackTop;                // Slot of the newest freed array

  assign stackTop = arrayNumber_t'(freedTop - 1'b1);

  // ------------------------------
  // Status towards the controller
  // ------------------------------
  assign allocPort.granted   = (freedTop != '0) ? freedStack[stackTop]
                                                : arrayNumber_t'(freshCount);
  assign allocPort.exhausted = (freedTop == '0) && (freshCount == arrayCount_t'(numArrays));
  assign allocPort.allocated = allocatedFlags[allocPort.array];

  // ------------------------------
  // Bookkeeping
  // ------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      freshCount     <= '0;
      freedTop       <= '0;
      allocatedFlags <= '0;
    end else if (allocPort.clearAll) begin
      freshCount     <= '0;   // Start handing out from array 0
      freedTop       <= '0;
      allocatedFlags <= '0;
    end else if (allocPort.allocate) begin
      allocatedFlags[allocPort.granted] <= 1'b1;
      if (freedTop != '0) begin
        freedTop <= freedTop - 1'b1;  // Reuse newest freed array
      end else begin
        freshCount <= freshCount + 1'b1;
      end
    end else if (allocPort.releaseArray) begin
      allocatedFlags[allocPort.array] <= 1'b0;
      freedTop                        <= freedTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (allocPort.releaseArray) begin
      freedStack[arrayNumber_t'(freedTop)] <= allocPort.array;  // Push freed number
    end
  end

  // Only arrays that were handed out can come back
  assert property (@(posedge clock) disable iff (!reset)
    (freedTop <= freshCount) && (freshCount <= arrayCount_t'(numArrays)))
    else $error("freed stack holds %0d entries with %0d arrays handed out",
                freedTop, freshCount);

endmodule

/* source/heapStoreIf.sv */
`timescale 1ns/1ns
/*
  Element store port
  Update strobes from the controller, element and size views back
*/
interface heapStoreIf #(
  parameter int addressBits = 2,
  parameter int indexBits   = 2,
  parameter int dataBits    = 12
);

  typedef logic [addressBits-1:0] arrayNumber_t;
  typedef logic [indexBits-1:0]   elementIndex_t;
  typedef logic [indexBits:0]     arraySize_t;
  typedef logic [dataBits-1:0]    dataWord_t;

  arrayNumber_t  array;         // Addressed array
  elementIndex_t index;         // Addressed element
  dataWord_t     data;          // Word to store or add
  logic          writeElement;  // One-hot update strobes
  logic          pushElement;
  logic          popElement;
  logic          addElement;
  logic          clearSize;     // Empty the addressed array
  arraySize_t    size;          // Size of the addressed array
  dataWord_t     element;       // Element at index
  dataWord_t     top;           // Last element below size
  dataWord_t     sum;           // Element plus data

  modport control (
    output array, index, data, writeElement, pushElement, popElement, addElement, clearSize,
    input  size, element, top, sum
  );

  modport store (
    input  array, index, data, writeElement, pushElement, popElement, addElement, clearSize,
    output size, element, top, sum
  );

endinterface

/* source/heapAllocIf.sv */
`timescale 1ns/1ns
/*
  Allocator port
  Grant, release and clear requests from the controller, allocation status back
*/
interface heapAllocIf #(
  parameter int addressBits = 2
);

  typedef logic [addressBits-1:0] arrayNumber_t;

  logic         allocate;      // Grant the next array
  logic         releaseArray;  // Free the addressed array
  logic         clearAll;      // Free every array
  arrayNumber_t array;         // Addressed array
  arrayNumber_t granted;       // Array the next grant returns
  logic         exhausted;     // Nothing left to grant
  logic         allocated;     // Addressed array is in use

  modport control (
    output allocate, releaseArray, clearAll, array,
    input  granted, exhausted, allocated
  );

  modport allocator (
    input  allocate, releaseArray, clearAll, array,
    output granted, exhausted, allocated
  );

endinterface

/* source/heapPkg.sv */
/*
  Heap memory shared definitions
  Action codes, error codes and default sizes of the array heap
*/
package heapPkg;

  // ------------------------------
  // Command actions
  // ------------------------------
  typedef enum logic [4:0] {
    actionReset = 5'd1,   // Free all arrays
    actionWrite = 5'd2,   // Store an element
    actionRead  = 5'd3,   // Fetch an element
    actionSize  = 5'd4,   // Current array size
    actionPush  = 5'd14,  // Append at the end
    actionPop   = 5'd15,  // Remove from the end
    actionAlloc = 5'd18,  // Grant a new array
    actionFree  = 5'd19,  // Return an array
    actionAdd   = 5'd20   // Add in place, new value out
  } heapAction_t;

  // ------------------------------
  // Command errors
  // ------------------------------
  typedef enum logic [2:0] {
    errorNone         = 3'd0,
    errorNotAllocated = 3'd1,  // Array not in use
    errorOutOfBounds  = 3'd2,  // Index at or past size
    errorOverflow     = 3'd3,  // Push on a full array
    errorUnderflow    = 3'd4,  // Pop on an empty array
    errorOutOfMemory  = 3'd5   // No array left to grant
  } heapError_t;

  // ------------------------------
  // Default sizes
  // ------------------------------
  localparam int defaultAddressBits = 2;   // Four arrays
  localparam int defaultIndexBits   = 2;   // Four elements each
  localparam int defaultDataBits    = 12;  // Element width

endpackage
